//--- Bender.yml
package:
  name: mini_mips

sources:
  - verilog/mips_pkg.sv
  - verilog/register_file.sv
  - verilog/fetch_unit.sv
  - verilog/decode_unit.sv
  - verilog/hazard_unit.sv
  - verilog/execute_unit.sv
  - verilog/memory_unit.sv
  - verilog/mips_core.sv
  - target: test
    files:
      - tb/mips_core_tb.sv

//--- mini_mips.f
verilog/mips_pkg.sv
verilog/register_file.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/hazard_unit.sv
verilog/execute_unit.sv
verilog/memory_unit.sv
verilog/mips_core.sv
tb/mips_core_tb.sv

//--- tb/mips_core_tb.sv
`default_nettype none

module mips_core_tb;
    import mips_pkg::*;

    localparam int PAT_WORDS       = 256;
    localparam int TRACE_BASE      = 64;   // first word of the trace in the pattern file
    localparam int CYCLES_PER_WORD = 20;
    localparam logic [31:0] END_MARK = 32'hffff_ffff;
    localparam logic [31:0] SEED     = 32'hbc7b;

    logic                  clk = 1'b0;
    logic                  rst_n = 1'b0;
    logic                  inst_stall = 1'b0;
    logic                  data_stall = 1'b0;
    logic [DATA_W-1:0]     rom_data, ram_data;
    logic                  rom_ce, ram_we, ram_ce, stall_all;
    logic [DATA_W-1:0]     rom_addr, ram_wdata, ram_addr;
    logic [3:0]            ram_sel, wb_wen;
    logic [DATA_W-1:0]     wb_pc, wb_wdata;
    logic [REG_ADDR_W-1:0] wb_wnum;

    logic [31:0] pat [PAT_WORDS];
    logic [31:0] ram [64];
    logic [31:0] rng;
    logic        checking = 1'b0;
    logic        stall_en = 1'b0;
    int          prog_len, trace_len, trace_idx, pass_no;
    int          err_count, test_errs, tests_ok, tests_bad;

    mips_core UUT (
        .clk_i(clk), .rst_n_i(rst_n), .rom_data_i(rom_data), .ram_data_i(ram_data),
        .inst_stall_i(inst_stall), .data_stall_i(data_stall),
        .rom_ce_o(rom_ce), .rom_addr_o(rom_addr),
        .ram_wdata_o(ram_wdata), .ram_addr_o(ram_addr), .ram_sel_o(ram_sel),
        .ram_we_o(ram_we), .ram_ce_o(ram_ce), .stall_all_o(stall_all),
        .debug_wb_pc_o(wb_pc), .debug_wb_rf_wen_o(wb_wen),
        .debug_wb_rf_wnum_o(wb_wnum), .debug_wb_rf_wdata_o(wb_wdata)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // memory models
    assign rom_data = (rom_addr[31:2] < prog_len) ? pat[rom_addr[9:2]] : '0; // nop past the end
    assign ram_data = ram_ce ? ram[ram_addr[7:2]] : '0;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= 32'h5a00_0000 | i; // fresh contents each pass
            end
        end else if (ram_ce && ram_we) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_sel[i]) ram[ram_addr[7:2]][8*i +: 8] <= ram_wdata[8*i +: 8];
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // random stall pulses on each input about one cycle in four
    always @(posedge clk) begin
        if (!rst_n) rng = SEED;
        else rng = lcg_next(rng);
        inst_stall <= stall_en && rng[31:30] == 2'b00;
        data_stall <= stall_en && rng[27:26] == 2'b00;
    end

    //////////////////////////////////////////////////////////////////////
    // trace checker
    task automatic report_test(input int tag);
        if (test_errs == 0) tests_ok++;
        else tests_bad++;
        $display("pass %0d test %0d: %s", pass_no, tag, test_errs == 0 ? "ok" : "mismatch");
        test_errs = 0;
    endtask

    task automatic check_write();
        int   base;
        logic ok;
        base = TRACE_BASE + 4 * trace_idx;
        if (trace_idx >= trace_len) begin
            err_count++;
            assert (trace_idx < trace_len) else
                $display("[ERROR] %0t: pass %0d extra write r%0d=%h at pc %h after the trace",
                         $time, pass_no, wb_wnum, wb_wdata, wb_pc);
        end else begin
            ok = wb_wen == 4'hf && wb_pc == pat[base+1] && wb_wnum == pat[base+2][4:0] &&
                 wb_wdata == pat[base+3];
            if (!ok) begin
                err_count++;
                test_errs++;
            end
            assert (ok) else
                $display("[ERROR] %0t: pass %0d test %0d got r%0d=%h pc %h, want r%0d=%h pc %h",
                         $time, pass_no, pat[base], wb_wnum, wb_wdata, wb_pc,
                         pat[base+2], pat[base+3], pat[base+1]);
            trace_idx++;
            if (pat[base+4] != pat[base]) report_test(pat[base]); // last entry of this test
        end
    endtask

    // entries are taken at negedge and move on at the next unstalled edge
    always @(negedge clk) begin : sample_proc
        logic stall_ok;
        if (rst_n) begin
            stall_ok = stall_all === (inst_stall | data_stall);
            if (!stall_ok) err_count++;
            assert (stall_ok) else
                $display("[ERROR] %0t: stall_all_o is %b with stall inputs %b %b",
                         $time, stall_all, inst_stall, data_stall);
            if (checking && wb_wen != 4'h0 && !stall_all) check_write();
        end
    end

    //////////////////////////////////////////////////////////////////////
    task automatic run_pass(input logic with_stalls);
        logic ok;
        @(posedge clk);
        rst_n    <= 1'b0;
        stall_en <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        ok = rom_addr == RESET_PC && !ram_we && !ram_ce && !stall_all && wb_wen == 4'h0;
        if (!ok) err_count++;
        assert (ok) else
            $display("[ERROR] %0t: pc or control outputs not at their reset values", $time);
        @(posedge clk);
        rst_n     <= 1'b1;
        stall_en  <= with_stalls;
        trace_idx = 0;
        test_errs = 0;
        checking  = 1'b1;
        wait (trace_idx == trace_len);
        ok = rom_ce === 1'b1;
        if (!ok) err_count++;
        assert (ok) else
            $display("[ERROR] %0t: rom_ce_o is low while the program runs", $time);
        repeat (8) @(posedge clk); // nothing else may retire
        checking = 1'b0;
    endtask

    initial begin
        err_count = 0;
        tests_ok  = 0;
        tests_bad = 0;
        $readmemh("tb/mips_patterns.mem", pat);
        prog_len = 0;
        while (prog_len < TRACE_BASE && pat[prog_len] !== END_MARK) prog_len++;
        trace_len = 0;
        while (TRACE_BASE + 4 * trace_len < PAT_WORDS &&
               pat[TRACE_BASE + 4 * trace_len] !== END_MARK) trace_len++;
        if (trace_len == 0) err_count++;
        assert (trace_len > 0) else
            $display("pattern file tb/mips_patterns.mem holds no expected writes");
        for (pass_no = 1; pass_no <= 2; pass_no++) begin
            run_pass(pass_no == 2); // second pass under random stalls
        end
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_ok, tests_bad, err_count);
        if (err_count == 0 && tests_bad == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog
    initial begin
        int limit;
        wait (prog_len > 0);
        limit = 2 * CYCLES_PER_WORD * prog_len + 100;
        repeat (limit) @(posedge clk);
        $display("timeout: expected writes still missing after %0d cycles", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/mips_patterns.mem
// words 0x00 to 0x3f: program, ffffffff after the last instruction
// words from 0x40: test  pc  reg  data of each register write in order, test ffffffff ends
@0
24010005 2402fffd 34038001 3c041234 // immediates
34845678 00222821 00223023 00863824 // alu ops
00614025 00824826 0041502a 0022582a
240c0011 018c6821 01ac7021 01cc7823 // dependent chain
01ed8021 ac040010 a0020011 8c110010 // stores then loads
80120011 02519821 80140013 26950001
10210002 24160022 24160bad 14210001 // branches, delay slots
24170023 24180024 17010002 24190025
24190bad 12d70002 241a0026 241b0027
1000ffff 00000000 ffffffff          // spin at 0x90
@40
00000001 00000000 00000001 00000005
00000001 00000004 00000002 fffffffd
00000001 00000008 00000003 00008001
00000001 0000000c 00000004 12340000
00000001 00000010 00000004 12345678
00000002 00000014 00000005 00000002
00000002 00000018 00000006 00000008
00000002 0000001c 00000007 00000008
00000002 00000020 00000008 00008005
00000002 00000024 00000009 edcba985
00000002 00000028 0000000a 00000001
00000002 0000002c 0000000b 00000000
00000003 00000030 0000000c 00000011
00000003 00000034 0000000d 00000022
00000003 00000038 0000000e 00000033
00000003 0000003c 0000000f 00000022
00000003 00000040 00000010 00000044
00000004 0000004c 00000011 1234fd78
00000004 00000050 00000012 fffffffd
00000004 00000054 00000013 1234fd75
00000004 00000058 00000014 00000012
00000004 0000005c 00000015 00000013
00000005 00000064 00000016 00000022
00000005 00000070 00000017 00000023
00000005 00000074 00000018 00000024
00000005 0000007c 00000019 00000025
00000005 00000088 0000001a 00000026
00000005 0000008c 0000001b 00000027
ffffffff 00000000 00000000 00000000

//--- verilog/decode_unit.sv
`default_nettype none

module decode_unit (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  mips_pkg::if_id_t                if_id_i,
    input  logic                            hold_i,
    input  logic                            bubble_i,
    input  logic [mips_pkg::DATA_W-1:0]     rdata_a_i,
    input  logic [mips_pkg::DATA_W-1:0]     rdata_b_i,
    input  mips_pkg::fwd_t                  ex_fwd_i,
    input  mips_pkg::fwd_t                  mem_fwd_i,
    input  mips_pkg::fwd_t                  wb_fwd_i,
    output logic [mips_pkg::REG_ADDR_W-1:0] raddr_a_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] raddr_b_o,
    output logic                            branch_taken_o,
    output logic [mips_pkg::DATA_W-1:0]     branch_target_o,
    output logic                            rs_use_o,
    output logic                            rt_use_o,
    output mips_pkg::id_ex_t                id_ex_o
);
    import mips_pkg::*;

    instr_u            ins;
    logic [DATA_W-1:0] val_a, val_b, imm_sext, imm_zext;
    logic              use_imm, zero_ext, is_beq, is_bne;
    id_ex_t            id_ex_n;

    // youngest producer wins
    function automatic logic [DATA_W-1:0] fwd_pick(
        input logic [REG_ADDR_W-1:0] ra,
        input logic [DATA_W-1:0]     rf,
        input fwd_t                  ex,
        input fwd_t                  mem,
        input fwd_t                  wb
    );
        logic [DATA_W-1:0] v;
        v = rf;
        if (ra != '0) begin
            if (ex.reg_we && ex.dest == ra) v = ex.data;
            else if (mem.reg_we && mem.dest == ra) v = mem.data;
            else if (wb.reg_we && wb.dest == ra) v = wb.data;
        end
        return v;
    endfunction

    assign ins       = if_id_i.instr;
    assign raddr_a_o = ins.r_fields.rs;
    assign raddr_b_o = ins.r_fields.rt;
    assign val_a     = fwd_pick(ins.r_fields.rs, rdata_a_i, ex_fwd_i, mem_fwd_i, wb_fwd_i);
    assign val_b     = fwd_pick(ins.r_fields.rt, rdata_b_i, ex_fwd_i, mem_fwd_i, wb_fwd_i);
    assign imm_sext  = {{16{ins.i_fields.imm[15]}}, ins.i_fields.imm};
    assign imm_zext  = {16'b0, ins.i_fields.imm};

    //////////////////////////////////////////////////////////////////////
    // control decode
    always_comb begin
        id_ex_n             = '0;
        id_ex_n.alu_op      = ALU_ADD;
        id_ex_n.dest        = ins.i_fields.rt;
        {use_imm, zero_ext, is_beq, is_bne, rs_use_o, rt_use_o} = '0;
        case (ins.r_fields.opcode)
            OP_SPECIAL: begin
                id_ex_n.dest   = ins.r_fields.rd;
                id_ex_n.reg_we = 1'b1;
                {rs_use_o, rt_use_o} = 2'b11;
                case (ins.r_fields.funct)
                    FN_ADDU: id_ex_n.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_n.alu_op = ALU_SUB;
                    FN_AND:  id_ex_n.alu_op = ALU_AND;
                    FN_OR:   id_ex_n.alu_op = ALU_OR;
                    FN_XOR:  id_ex_n.alu_op = ALU_XOR;
                    FN_SLT:  id_ex_n.alu_op = ALU_SLT;
                    default: begin // nop and anything unsupported
                        id_ex_n.reg_we = 1'b0;
                        {rs_use_o, rt_use_o} = 2'b00;
                    end
                endcase
            end
            OP_ADDIU: {id_ex_n.reg_we, rs_use_o, use_imm} = 3'b111;
            OP_ORI: begin
                id_ex_n.alu_op = ALU_OR;
                {id_ex_n.reg_we, rs_use_o, use_imm, zero_ext} = 4'b1111;
            end
            OP_LUI: begin
                id_ex_n.alu_op = ALU_LUI;
                {id_ex_n.reg_we, use_imm, zero_ext} = 3'b111;
            end
            OP_LW: {id_ex_n.reg_we, id_ex_n.mem_rd, rs_use_o, use_imm} = 4'b1111;
            OP_LB: begin
                {id_ex_n.reg_we, id_ex_n.mem_rd, rs_use_o, use_imm} = 4'b1111;
                {id_ex_n.byte_acc, id_ex_n.load_signed} = 2'b11;
            end
            OP_SW: {id_ex_n.mem_wr, rs_use_o, rt_use_o, use_imm} = 4'b1111;
            OP_SB: {id_ex_n.mem_wr, id_ex_n.byte_acc, rs_use_o, rt_use_o, use_imm} = 5'h1f;
            OP_BEQ: {is_beq, rs_use_o, rt_use_o} = 3'b111;
            OP_BNE: {is_bne, rs_use_o, rt_use_o} = 3'b111;
            default: ;
        endcase
        id_ex_n.operand_a  = val_a;
        id_ex_n.operand_b  = use_imm ? (zero_ext ? imm_zext : imm_sext) : val_b;
        id_ex_n.store_data = val_b;
        id_ex_n.pc         = if_id_i.pc;
    end

    assign branch_taken_o  = (is_beq && val_a == val_b) || (is_bne && val_a != val_b);
    assign branch_target_o = if_id_i.pc + 32'd4 + {imm_sext[DATA_W-3:0], 2'b00};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_ex_o.reg_we <= 1'b0;
            id_ex_o.mem_rd <= 1'b0;
            id_ex_o.mem_wr <= 1'b0;
        end else if (!hold_i) begin
            id_ex_o <= id_ex_n;
            if (bubble_i) begin // load-use slot
                id_ex_o.reg_we <= 1'b0;
                id_ex_o.mem_rd <= 1'b0;
                id_ex_o.mem_wr <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/execute_unit.sv
`default_nettype none

module execute_unit (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            hold_i,
    input  mips_pkg::id_ex_t                id_ex_i,
    output mips_pkg::fwd_t                  ex_fwd_o,
    output logic                            ex_mem_rd_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] ex_dest_o,
    output mips_pkg::ex_mem_t               ex_mem_o
);
    import mips_pkg::*;

    logic [DATA_W-1:0] a, b, alu_res;

    assign a = id_ex_i.operand_a;
    assign b = id_ex_i.operand_b;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB: alu_res = a - b;
            ALU_AND: alu_res = a & b;
            ALU_OR:  alu_res = a | b;
            ALU_XOR: alu_res = a ^ b;
            ALU_SLT: alu_res = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_LUI: alu_res = {b[15:0], 16'b0};
            default: alu_res = a + b; // also load/store address
        endcase
    end

    // load data only exists one stage later
    assign ex_fwd_o    = '{reg_we: id_ex_i.reg_we & ~id_ex_i.mem_rd,
                           dest: id_ex_i.dest, data: alu_res};
    assign ex_mem_rd_o = id_ex_i.mem_rd;
    assign ex_dest_o   = id_ex_i.dest;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_mem_o.reg_we <= 1'b0;
            ex_mem_o.mem_rd <= 1'b0;
            ex_mem_o.mem_wr <= 1'b0;
        end else if (!hold_i) begin
            ex_mem_o.result      <= alu_res;
            ex_mem_o.store_data  <= id_ex_i.store_data;
            ex_mem_o.dest        <= id_ex_i.dest;
            ex_mem_o.reg_we      <= id_ex_i.reg_we;
            ex_mem_o.mem_rd      <= id_ex_i.mem_rd;
            ex_mem_o.mem_wr      <= id_ex_i.mem_wr;
            ex_mem_o.byte_acc    <= id_ex_i.byte_acc;
            ex_mem_o.load_signed <= id_ex_i.load_signed;
            ex_mem_o.pc          <= id_ex_i.pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        hold_i,
    input  logic                        branch_taken_i,
    input  logic [mips_pkg::DATA_W-1:0] branch_target_i,
    input  logic [mips_pkg::DATA_W-1:0] rom_data_i,
    output logic [mips_pkg::DATA_W-1:0] rom_addr_o,
    output logic                        rom_ce_o,
    output mips_pkg::if_id_t            if_id_o
);
    import mips_pkg::*;

    logic [DATA_W-1:0] pc_q;

    assign rom_addr_o = pc_q; // rom answers in the same cycle

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q          <= RESET_PC;
            rom_ce_o      <= 1'b0;
            if_id_o.pc    <= RESET_PC;
            if_id_o.instr <= '0; // decodes as a no-op
        end else begin
            rom_ce_o <= 1'b1;
            if (!hold_i) begin
                // branch in decode now, so this fetch is its delay slot
                pc_q          <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
                if_id_o.pc    <= pc_q;
                if_id_o.instr <= rom_data_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
`default_nettype none

module hazard_unit (
    input  mips_pkg::if_id_t                if_id_i,
    input  logic                            rs_use_i,
    input  logic                            rt_use_i,
    input  logic                            ex_mem_rd_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] ex_dest_i,
    input  logic                            inst_stall_i,
    input  logic                            data_stall_i,
    output logic                            fetch_hold_o,
    output logic                            decode_bubble_o,
    output logic                            pipe_hold_o,
    output logic                            stall_all_o
);
    import mips_pkg::*;

    logic [REG_ADDR_W-1:0] rs, rt;
    logic                  load_use, ext_stall;

    assign rs = if_id_i.instr.i_fields.rs;
    assign rt = if_id_i.instr.i_fields.rt;

    // load result not ready until memory stage
    assign load_use = ex_mem_rd_i && ex_dest_i != '0 &&
                      ((rs_use_i && rs == ex_dest_i) || (rt_use_i && rt == ex_dest_i));

    assign ext_stall       = inst_stall_i | data_stall_i;
    assign stall_all_o     = ext_stall;
    assign pipe_hold_o     = ext_stall;                 // whole pipe frozen
    assign fetch_hold_o    = ext_stall | load_use;
    assign decode_bubble_o = load_use & ~ext_stall;

endmodule

`default_nettype wire

//--- verilog/memory_unit.sv
`default_nettype none

module memory_unit (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            hold_i,
    input  mips_pkg::ex_mem_t               ex_mem_i,
    input  logic [mips_pkg::DATA_W-1:0]     ram_data_i,
    output logic [mips_pkg::DATA_W-1:0]     ram_addr_o,
    output logic [mips_pkg::DATA_W-1:0]     ram_wdata_o,
    output logic [3:0]                      ram_sel_o,
    output logic                            ram_we_o,
    output logic                            ram_ce_o,
    output mips_pkg::fwd_t                  mem_fwd_o,
    output mips_pkg::fwd_t                  wb_fwd_o,
    output logic                            reg_we_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] reg_waddr_o,
    output logic [mips_pkg::DATA_W-1:0]     reg_wdata_o,
    output logic [mips_pkg::DATA_W-1:0]     debug_wb_pc_o,
    output logic [3:0]                      debug_wb_rf_wen_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [mips_pkg::DATA_W-1:0]     debug_wb_rf_wdata_o
);
    import mips_pkg::*;

    logic [1:0]        lane;
    logic [7:0]        ld_byte;
    logic [DATA_W-1:0] ld_val, wb_val;
    mem_wb_t           mem_wb_q;

    assign lane        = ex_mem_i.result[1:0];
    assign ram_addr_o  = {ex_mem_i.result[DATA_W-1:2], 2'b00};
    assign ram_sel_o   = ex_mem_i.byte_acc ? (4'b0001 << lane) : 4'b1111; // little endian
    assign ram_wdata_o = ex_mem_i.byte_acc ? {4{ex_mem_i.store_data[7:0]}} : ex_mem_i.store_data;
    assign ram_we_o    = ex_mem_i.mem_wr;
    assign ram_ce_o    = ex_mem_i.mem_rd | ex_mem_i.mem_wr;

    // load alignment and extension
    assign ld_byte = ram_data_i[{lane, 3'b000} +: 8];
    assign ld_val  = !ex_mem_i.byte_acc   ? ram_data_i :
                     ex_mem_i.load_signed ? {{24{ld_byte[7]}}, ld_byte} : {24'b0, ld_byte};
    assign wb_val  = ex_mem_i.mem_rd ? ld_val : ex_mem_i.result;

    assign mem_fwd_o = '{reg_we: ex_mem_i.reg_we, dest: ex_mem_i.dest, data: wb_val};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_wb_q.reg_we <= 1'b0;
        end else if (!hold_i) begin
            mem_wb_q <= '{pc: ex_mem_i.pc, dest: ex_mem_i.dest,
                          reg_we: ex_mem_i.reg_we, wdata: wb_val};
        end
    end

    // held under stall, so an entry retires on the first unstalled edge
    assign wb_fwd_o    = '{reg_we: mem_wb_q.reg_we, dest: mem_wb_q.dest, data: mem_wb_q.wdata};
    assign reg_we_o    = mem_wb_q.reg_we;
    assign reg_waddr_o = mem_wb_q.dest;
    assign reg_wdata_o = mem_wb_q.wdata;

    assign debug_wb_pc_o       = mem_wb_q.pc;
    assign debug_wb_rf_wen_o   = {4{mem_wb_q.reg_we}};
    assign debug_wb_rf_wnum_o  = mem_wb_q.dest;
    assign debug_wb_rf_wdata_o = mem_wb_q.wdata;

endmodule

`default_nettype wire

//--- verilog/mips_core.sv
`default_nettype none

module mips_core (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [mips_pkg::DATA_W-1:0]     rom_data_i,
    input  logic [mips_pkg::DATA_W-1:0]     ram_data_i,
    input  logic                            inst_stall_i,
    input  logic                            data_stall_i,
    output logic                            rom_ce_o,
    output logic [mips_pkg::DATA_W-1:0]     rom_addr_o,
    output logic [mips_pkg::DATA_W-1:0]     ram_wdata_o,
    output logic [mips_pkg::DATA_W-1:0]     ram_addr_o,
    output logic [3:0]                      ram_sel_o,
    output logic                            ram_we_o,
    output logic                            ram_ce_o,
    output logic                            stall_all_o,
    output logic [mips_pkg::DATA_W-1:0]     debug_wb_pc_o,
    output logic [3:0]                      debug_wb_rf_wen_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [mips_pkg::DATA_W-1:0]     debug_wb_rf_wdata_o
);
    import mips_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // stage links
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    fwd_t    ex_fwd, mem_fwd, wb_fwd;

    logic                  branch_taken, rs_use, rt_use, ex_mem_rd;
    logic [DATA_W-1:0]     branch_target, rdata_a, rdata_b, reg_wdata;
    logic [REG_ADDR_W-1:0] raddr_a, raddr_b, ex_dest, reg_waddr;
    logic                  fetch_hold, decode_bubble, pipe_hold, reg_we;

    fetch_unit u_fetch (
        .clk_i, .rst_n_i, .hold_i(fetch_hold),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .rom_data_i, .rom_addr_o, .rom_ce_o, .if_id_o(if_id)
    );

    decode_unit u_decode (
        .clk_i, .rst_n_i, .if_id_i(if_id), .hold_i(pipe_hold), .bubble_i(decode_bubble),
        .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd), .wb_fwd_i(wb_fwd),
        .raddr_a_o(raddr_a), .raddr_b_o(raddr_b),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .rs_use_o(rs_use), .rt_use_o(rt_use), .id_ex_o(id_ex)
    );

    hazard_unit u_hazard (
        .if_id_i(if_id), .rs_use_i(rs_use), .rt_use_i(rt_use),
        .ex_mem_rd_i(ex_mem_rd), .ex_dest_i(ex_dest),
        .inst_stall_i, .data_stall_i,
        .fetch_hold_o(fetch_hold), .decode_bubble_o(decode_bubble),
        .pipe_hold_o(pipe_hold), .stall_all_o
    );

    execute_unit u_execute (
        .clk_i, .rst_n_i, .hold_i(pipe_hold), .id_ex_i(id_ex),
        .ex_fwd_o(ex_fwd), .ex_mem_rd_o(ex_mem_rd), .ex_dest_o(ex_dest), .ex_mem_o(ex_mem)
    );

    memory_unit u_memory (
        .clk_i, .rst_n_i, .hold_i(pipe_hold), .ex_mem_i(ex_mem), .ram_data_i,
        .ram_addr_o, .ram_wdata_o, .ram_sel_o, .ram_we_o, .ram_ce_o,
        .mem_fwd_o(mem_fwd), .wb_fwd_o(wb_fwd),
        .reg_we_o(reg_we), .reg_waddr_o(reg_waddr), .reg_wdata_o(reg_wdata),
        .debug_wb_pc_o, .debug_wb_rf_wen_o, .debug_wb_rf_wnum_o, .debug_wb_rf_wdata_o
    );

    register_file u_regfile (
        .clk_i, .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
        .we_i(reg_we), .waddr_i(reg_waddr), .wdata_i(reg_wdata),
        .rdata_a_o(rdata_a), .rdata_b_o(rdata_b)
    );

endmodule

`default_nettype wire

//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [DATA_W-1:0] RESET_PC = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_LB      = 6'b100000;
    localparam logic [5:0] OP_SW      = 6'b101011;
    localparam logic [5:0] OP_SB      = 6'b101000;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;

    localparam logic [5:0] FN_ADDU = 6'b100001; // funct under SPECIAL
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // instruction word, two views
    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    //////////////////////////////////////////////////////////////////////
    // stage registers
    typedef struct packed {
        logic [DATA_W-1:0] pc;
        instr_u            instr;
    } if_id_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [DATA_W-1:0]     operand_a;
        logic [DATA_W-1:0]     operand_b;
        logic [DATA_W-1:0]     store_data;
        logic [REG_ADDR_W-1:0] dest;
        logic                  reg_we;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  byte_acc;
        logic                  load_signed;
        logic [DATA_W-1:0]     pc;
    } id_ex_t;

    typedef struct packed {
        logic [DATA_W-1:0]     result;     // alu result or effective address
        logic [DATA_W-1:0]     store_data;
        logic [REG_ADDR_W-1:0] dest;
        logic                  reg_we;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  byte_acc;
        logic                  load_signed;
        logic [DATA_W-1:0]     pc;
    } ex_mem_t;

    typedef struct packed {
        logic [DATA_W-1:0]     pc;
        logic [REG_ADDR_W-1:0] dest;
        logic                  reg_we;
        logic [DATA_W-1:0]     wdata;
    } mem_wb_t;

    typedef struct packed {
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     data;
    } fwd_t;

endpackage

`default_nettype wire

//--- verilog/register_file.sv
`default_nettype none

module register_file (
    input  logic                            clk_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr_b_i,
    input  logic                            we_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [mips_pkg::DATA_W-1:0]     wdata_i,
    output logic [mips_pkg::DATA_W-1:0]     rdata_a_o,
    output logic [mips_pkg::DATA_W-1:0]     rdata_b_o
);
    import mips_pkg::*;

    logic [DATA_W-1:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write shows up on the read side
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : // r0 hardwired
                       (we_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       (we_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule

`default_nettype wire
